//--- Bender.yml
package:
  name: srf

sources:
  - src/srf_pkg.sv
  - src/srf_rf_if.sv
  - src/srf_ram_if.sv
  - src/srf_ram.sv
  - src/srf_top.sv
  - target: test
    files:
      - testbench/srf_tb.sv

//--- src/srf_pkg.sv
package srf_pkg;

   // Register length and memory word size
   localparam int XLEN     = 32;
   localparam int RF_WIDTH = 2;

   // Register address: 0xxxxx general register, 1000xx CSR slot
   localparam int RREG_BITS = 6;
   localparam int RF_REGS   = 36;

   // Memory geometry
   localparam int RF_DEPTH  = RF_REGS * XLEN / RF_WIDTH;
   localparam int RF_AW     = $clog2(RF_DEPTH);
   localparam int WORD_BITS = $clog2(XLEN / RF_WIDTH);

   // Bit counter over one register
   localparam int CNT_BITS = $clog2(XLEN);

   // Upper address bits of the CSR region
   localparam logic [3:0] CSR_BASE = 4'b1000;

   // CSR slots behind CSR_BASE
   typedef enum logic [1:0] {
      CSR_MSCRATCH = 2'd0,
      CSR_MTVEC    = 2'd1,
      CSR_MEPC     = 2'd2,
      CSR_MTVAL    = 2'd3
   } csr_slot_e;

   // Memory sequencer states
   typedef enum logic [1:0] {
      ST_IDLE,
      ST_PREFETCH,
      ST_DATA
   } ram_state_e;

endpackage

//--- src/srf_ram.sv
`timescale 1ns/1ps
`default_nettype none
module srf_ram (
   input  logic                         i_clk,
   input  logic [srf_pkg::RF_AW-1:0]    i_waddr,
   input  logic [srf_pkg::RF_WIDTH-1:0] i_wdata,
   input  logic                         i_wen,
   input  logic [srf_pkg::RF_AW-1:0]    i_raddr,
   output logic [srf_pkg::RF_WIDTH-1:0] o_rdata
);

   import srf_pkg::*;

   logic [RF_WIDTH-1:0] mem [RF_DEPTH];

   // Block RAM powers up cleared, so x0 reads zero
   initial begin
      for (int i = 0; i < RF_DEPTH; i++) begin
         mem[i] = '0;
      end
   end

   always_ff @(posedge i_clk) begin
      if (i_wen) begin
         mem[i_waddr] <= i_wdata;
      end
      // Read returns the old word on an address collision
      o_rdata <= mem[i_raddr];
   end

endmodule

//--- src/srf_ram_if.sv
`timescale 1ns/1ps
`default_nettype none
module srf_ram_if (
   input  logic                          i_clk,
   input  logic                          i_reset,
   input  logic                          i_rreq,
   output logic                          o_ready,
   // Serial ports
   input  logic [srf_pkg::RREG_BITS-1:0] i_wreg0,
   input  logic [srf_pkg::RREG_BITS-1:0] i_wreg1,
   input  logic                          i_wen0,
   input  logic                          i_wen1,
   input  logic                          i_wdata0,
   input  logic                          i_wdata1,
   input  logic [srf_pkg::RREG_BITS-1:0] i_rreg0,
   input  logic [srf_pkg::RREG_BITS-1:0] i_rreg1,
   output logic                          o_rdata0,
   output logic                          o_rdata1,
   // Memory
   output logic [srf_pkg::RF_AW-1:0]     o_waddr,
   output logic [srf_pkg::RF_WIDTH-1:0]  o_wdata,
   output logic                          o_wen,
   output logic [srf_pkg::RF_AW-1:0]     o_raddr,
   input  logic [srf_pkg::RF_WIDTH-1:0]  i_rdata
);

   import srf_pkg::*;

   ram_state_e state;
   logic                 rreq_q;
   logic                 tail;
   logic [CNT_BITS-1:0]  cnt;
   logic [CNT_BITS-1:0]  cnt_ahead;
   logic [WORD_BITS-1:0] rword;
   logic [WORD_BITS-1:0] wword;
   logic                 wvalid;

   logic [RF_WIDTH-1:0]  rsh0;
   logic [RF_WIDTH-2:0]  rhold1;
   logic [RF_WIDTH-1:0]  wsh0;
   logic [RF_WIDTH:0]    wsh1;
   logic [RREG_BITS-1:0] wreg_q0;
   logic [RREG_BITS-1:0] wreg_q1;
   logic                 wen_q0;
   logic                 wen_q1;

   // Prefetch runs at count XLEN-2 and XLEN-1 so reads stay two bits ahead
   always_ff @(posedge i_clk) begin
      if (i_reset) begin
         state  <= ST_IDLE;
         rreq_q <= 1'b0;
         tail   <= 1'b0;
         cnt    <= '0;
      end else begin
         case (state)
            ST_IDLE: begin
               rreq_q <= i_rreq;
               if (rreq_q) begin
                  rreq_q <= 1'b0;
                  cnt    <= CNT_BITS'(XLEN - 2);
                  state  <= ST_PREFETCH;
               end
            end
            ST_PREFETCH: begin
               cnt <= cnt + 1'b1;
               if (cnt[0]) begin
                  state <= ST_DATA;
               end
            end
            ST_DATA: begin
               cnt <= cnt + 1'b1;
               if (&cnt) begin
                  tail <= 1'b1;
               end
               // Two extra cycles commit the last word of each port
               if (tail && cnt[0]) begin
                  tail  <= 1'b0;
                  state <= ST_IDLE;
               end
            end
            default: state <= ST_IDLE;
         endcase
      end
   end

   assign o_ready = (state == ST_PREFETCH) & cnt[0];

   // Even cycles belong to port 0, odd cycles to port 1
   assign cnt_ahead = cnt + CNT_BITS'(2);
   assign rword     = cnt_ahead[CNT_BITS-1:1];
   assign o_raddr   = {cnt[0] ? i_rreg1 : i_rreg0, rword};

   // Read data pipeline
   always_ff @(posedge i_clk) begin
      if (state != ST_IDLE) begin
         if (cnt[0]) begin
            rsh0 <= i_rdata;
         end else begin
            rsh0   <= rsh0 >> 1;
            rhold1 <= i_rdata[RF_WIDTH-1:1];
         end
      end
   end

   // Port 1 word arrives in its first bit cycle, so bit 0 bypasses the register
   assign o_rdata0 = rsh0[0];
   assign o_rdata1 = cnt[0] ? rhold1[0] : i_rdata[0];

   // Write bit collection, port 1 keeps one extra bit for its later slot
   always_ff @(posedge i_clk) begin
      if (state == ST_DATA) begin
         wsh0 <= {i_wdata0, wsh0[RF_WIDTH-1:1]};
         wsh1 <= {i_wdata1, wsh1[RF_WIDTH:1]};
         if (cnt[0] && !tail) begin
            wreg_q0 <= i_wreg0;
            wreg_q1 <= i_wreg1;
            wen_q0  <= i_wen0;
            wen_q1  <= i_wen1;
         end
      end
   end

   // No completed word before bit 2
   assign wvalid = tail | (cnt[CNT_BITS-1:1] != '0);
   assign wword  = cnt[CNT_BITS-1:1] - 1'b1;

   assign o_waddr = {cnt[0] ? wreg_q1 : wreg_q0, wword};
   assign o_wdata = cnt[0] ? wsh1[RF_WIDTH-1:0] : wsh0;
   assign o_wen   = (state == ST_DATA) & wvalid & (cnt[0] ? wen_q1 : wen_q0);

endmodule

//--- src/srf_rf_if.sv
`timescale 1ns/1ps
`default_nettype none
module srf_rf_if (
   // Memory side
   output logic [srf_pkg::RREG_BITS-1:0] o_wreg0,
   output logic [srf_pkg::RREG_BITS-1:0] o_wreg1,
   output logic                          o_wen0,
   output logic                          o_wen1,
   output logic                          o_wdata0,
   output logic                          o_wdata1,
   output logic [srf_pkg::RREG_BITS-1:0] o_rreg0,
   output logic [srf_pkg::RREG_BITS-1:0] o_rreg1,
   input  logic                          i_rdata0,
   input  logic                          i_rdata1,
   // Trap
   input  logic                          i_trap,
   input  logic                          i_mret,
   input  logic                          i_mepc,
   input  logic                          i_mem_op,
   input  logic                          i_bufreg_q,
   input  logic                          i_bad_pc,
   output logic                          o_csr_pc,
   // CSR
   input  logic                          i_csr_en,
   input  srf_pkg::csr_slot_e            i_csr_addr,
   input  logic                          i_csr,
   output logic                          o_csr,
   // rd write port
   input  logic                          i_rd_wen,
   input  logic [4:0]                    i_rd_waddr,
   input  logic                          i_ctrl_rd,
   input  logic                          i_alu_rd,
   input  logic                          i_rd_alu_en,
   input  logic                          i_csr_rd,
   input  logic                          i_rd_csr_en,
   input  logic                          i_mem_rd,
   // rs1 and rs2 read ports
   input  logic [4:0]                    i_rs1_raddr,
   output logic                          o_rs1,
   input  logic [4:0]                    i_rs2_raddr,
   output logic                          o_rs2
);

   import srf_pkg::*;

   logic rd_wen;
   logic rd;
   logic mtval;

   // x0 is never written
   assign rd_wen = i_rd_wen & (|i_rd_waddr);

   // Only one rd source is active per instruction
   assign rd = i_ctrl_rd |
               (i_alu_rd & i_rd_alu_en) |
               (i_csr_rd & i_rd_csr_en) |
               i_mem_rd;

   // Faulting address for loads/stores, else the bad PC
   assign mtval = i_mem_op ? i_bufreg_q : i_bad_pc;

   // Port 0 carries rd or mtval
   assign o_wdata0 = i_trap ? mtval : rd;
   assign o_wreg0  = i_trap ? {CSR_BASE, CSR_MTVAL} : {1'b0, i_rd_waddr};
   assign o_wen0   = i_trap | rd_wen;

   // Port 1 carries the CSR or mepc
   assign o_wdata1 = i_trap ? i_mepc : i_csr;
   assign o_wreg1  = i_trap ? {CSR_BASE, CSR_MEPC} : {CSR_BASE, i_csr_addr};
   assign o_wen1   = i_trap | i_csr_en;

   // Read port 0 is always rs1
   assign o_rreg0 = {1'b0, i_rs1_raddr};

   // Read port 1 is shared by rs2, CSRs and the trap/return PC
   always_comb begin
      if (i_trap) begin
         o_rreg1 = {CSR_BASE, CSR_MTVEC};
      end else if (i_mret) begin
         o_rreg1 = {CSR_BASE, CSR_MEPC};
      end else if (i_csr_en) begin
         o_rreg1 = {CSR_BASE, i_csr_addr};
      end else begin
         o_rreg1 = {1'b0, i_rs2_raddr};
      end
   end

   assign o_rs1    = i_rdata0;
   assign o_rs2    = i_rdata1;
   assign o_csr    = i_rdata1 & i_csr_en;
   assign o_csr_pc = i_rdata1;

endmodule

//--- src/srf_top.sv
`timescale 1ns/1ps
`default_nettype none
module srf_top (
   input  logic               i_clk,
   input  logic               i_reset,
   input  logic               i_rreq,
   output logic               o_ready,
   // Trap
   input  logic               i_trap,
   input  logic               i_mret,
   input  logic               i_mepc,
   input  logic               i_mem_op,
   input  logic               i_bufreg_q,
   input  logic               i_bad_pc,
   output logic               o_csr_pc,
   // CSR
   input  logic               i_csr_en,
   input  srf_pkg::csr_slot_e i_csr_addr,
   input  logic               i_csr,
   output logic               o_csr,
   // rd write port
   input  logic               i_rd_wen,
   input  logic [4:0]         i_rd_waddr,
   input  logic               i_ctrl_rd,
   input  logic               i_alu_rd,
   input  logic               i_rd_alu_en,
   input  logic               i_csr_rd,
   input  logic               i_rd_csr_en,
   input  logic               i_mem_rd,
   // Read ports
   input  logic [4:0]         i_rs1_raddr,
   output logic               o_rs1,
   input  logic [4:0]         i_rs2_raddr,
   output logic               o_rs2
);

   import srf_pkg::*;

   logic [RREG_BITS-1:0] wreg0;
   logic [RREG_BITS-1:0] wreg1;
   logic                 wen0;
   logic                 wen1;
   logic                 wdata0;
   logic                 wdata1;
   logic [RREG_BITS-1:0] rreg0;
   logic [RREG_BITS-1:0] rreg1;
   logic                 rdata0;
   logic                 rdata1;

   logic [RF_AW-1:0]     ram_waddr;
   logic [RF_WIDTH-1:0]  ram_wdata;
   logic                 ram_wen;
   logic [RF_AW-1:0]     ram_raddr;
   logic [RF_WIDTH-1:0]  ram_rdata;

   srf_rf_if u_rf_if (
      .o_wreg0     (wreg0),
      .o_wreg1     (wreg1),
      .o_wen0      (wen0),
      .o_wen1      (wen1),
      .o_wdata0    (wdata0),
      .o_wdata1    (wdata1),
      .o_rreg0     (rreg0),
      .o_rreg1     (rreg1),
      .i_rdata0    (rdata0),
      .i_rdata1    (rdata1),
      .i_trap      (i_trap),
      .i_mret      (i_mret),
      .i_mepc      (i_mepc),
      .i_mem_op    (i_mem_op),
      .i_bufreg_q  (i_bufreg_q),
      .i_bad_pc    (i_bad_pc),
      .o_csr_pc    (o_csr_pc),
      .i_csr_en    (i_csr_en),
      .i_csr_addr  (i_csr_addr),
      .i_csr       (i_csr),
      .o_csr       (o_csr),
      .i_rd_wen    (i_rd_wen),
      .i_rd_waddr  (i_rd_waddr),
      .i_ctrl_rd   (i_ctrl_rd),
      .i_alu_rd    (i_alu_rd),
      .i_rd_alu_en (i_rd_alu_en),
      .i_csr_rd    (i_csr_rd),
      .i_rd_csr_en (i_rd_csr_en),
      .i_mem_rd    (i_mem_rd),
      .i_rs1_raddr (i_rs1_raddr),
      .o_rs1       (o_rs1),
      .i_rs2_raddr (i_rs2_raddr),
      .o_rs2       (o_rs2)
   );

   srf_ram_if u_ram_if (
      .i_clk    (i_clk),
      .i_reset  (i_reset),
      .i_rreq   (i_rreq),
      .o_ready  (o_ready),
      .i_wreg0  (wreg0),
      .i_wreg1  (wreg1),
      .i_wen0   (wen0),
      .i_wen1   (wen1),
      .i_wdata0 (wdata0),
      .i_wdata1 (wdata1),
      .i_rreg0  (rreg0),
      .i_rreg1  (rreg1),
      .o_rdata0 (rdata0),
      .o_rdata1 (rdata1),
      .o_waddr  (ram_waddr),
      .o_wdata  (ram_wdata),
      .o_wen    (ram_wen),
      .o_raddr  (ram_raddr),
      .i_rdata  (ram_rdata)
   );

   srf_ram u_ram (
      .i_clk   (i_clk),
      .i_waddr (ram_waddr),
      .i_wdata (ram_wdata),
      .i_wen   (ram_wen),
      .i_raddr (ram_raddr),
      .o_rdata (ram_rdata)
   );

endmodule

//--- testbench/srf_tb.sv
`timescale 1ns/1ps
module srf_tb;

   import srf_pkg::*;

   localparam int CLK_PERIOD = 20;
   localparam int N_TXN      = 26;
   // About 39 cycles per transaction including the idle gap
   localparam int WATCHDOG_CYCLES = N_TXN * 45 + 60;

   logic       i_clk;
   logic       i_reset;
   logic       i_rreq;
   logic       o_ready;
   logic       i_trap;
   logic       i_mret;
   logic       i_mepc;
   logic       i_mem_op;
   logic       i_bufreg_q;
   logic       i_bad_pc;
   logic       o_csr_pc;
   logic       i_csr_en;
   csr_slot_e  i_csr_addr;
   logic       i_csr;
   logic       o_csr;
   logic       i_rd_wen;
   logic [4:0] i_rd_waddr;
   logic       i_ctrl_rd;
   logic       i_alu_rd;
   logic       i_rd_alu_en;
   logic       i_csr_rd;
   logic       i_rd_csr_en;
   logic       i_mem_rd;
   logic [4:0] i_rs1_raddr;
   logic       o_rs1;
   logic [4:0] i_rs2_raddr;
   logic       o_rs2;

   // Request fields for the next transaction
   logic [4:0]      q_rs1;
   logic [4:0]      q_rs2;
   logic [4:0]      q_rd;
   logic            q_rd_wen;
   int              q_src;
   logic            q_src_en;
   logic [XLEN-1:0] q_rd_val;
   logic            q_csr_en;
   logic [1:0]      q_slot;
   logic [XLEN-1:0] q_csr_val;
   logic            q_trap;
   logic            q_mret;
   logic            q_mem_op;
   logic [XLEN-1:0] q_mepc;
   logic [XLEN-1:0] q_bufreg;
   logic [XLEN-1:0] q_bad_pc;

   // Reference model, index 32 and up are the CSR slots
   logic [XLEN-1:0] model [RF_REGS];
   logic [XLEN-1:0] exp_rs1;
   logic [XLEN-1:0] exp_rs2;
   logic [XLEN-1:0] exp_csr;
   logic [XLEN-1:0] exp_csr_pc;
   logic            in_data;
   logic [4:0]      bit_idx;

   logic [31:0] lfsr;
   int          err_cnt;
   int          txn_cnt;
   int          test_cnt;
   int          test_err_start;
   string       cur_name;

   srf_top UUT (.*);

   always #(CLK_PERIOD / 2) i_clk = ~i_clk;

   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
   endfunction

   // One LFSR step per bit
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      int          i;
      v = '0;
      for (i = 0; i < n; i++) begin
         lfsr = lfsr_next(lfsr);
         v    = {v[30:0], lfsr[0]};
      end
      return v;
   endfunction

   // Ready follows the request by exactly 3 cycles and at no other time
   assert property (@(posedge i_clk) disable iff (i_reset) o_ready == $past(i_rreq, 3))
      else begin
         err_cnt++;
         $display("CHECK FAILED at %0t: o_ready = %b, expected %b",
                  $time, $sampled(o_ready), !$sampled(o_ready));
      end

   assert property (@(posedge i_clk) disable iff (i_reset) in_data |-> o_rs1 == exp_rs1[bit_idx])
      else begin
         err_cnt++;
         $display("CHECK FAILED at %0t: o_rs1 bit %0d = %b, expected %b", $time,
                  $sampled(bit_idx), $sampled(o_rs1), $sampled(exp_rs1[bit_idx]));
      end

   assert property (@(posedge i_clk) disable iff (i_reset) in_data |-> o_rs2 == exp_rs2[bit_idx])
      else begin
         err_cnt++;
         $display("CHECK FAILED at %0t: o_rs2 bit %0d = %b, expected %b", $time,
                  $sampled(bit_idx), $sampled(o_rs2), $sampled(exp_rs2[bit_idx]));
      end

   assert property (@(posedge i_clk) disable iff (i_reset) in_data |-> o_csr == exp_csr[bit_idx])
      else begin
         err_cnt++;
         $display("CHECK FAILED at %0t: o_csr bit %0d = %b, expected %b", $time,
                  $sampled(bit_idx), $sampled(o_csr), $sampled(exp_csr[bit_idx]));
      end

   assert property (@(posedge i_clk) disable iff (i_reset)
                    in_data |-> o_csr_pc == exp_csr_pc[bit_idx])
      else begin
         err_cnt++;
         $display("CHECK FAILED at %0t: o_csr_pc bit %0d = %b, expected %b", $time,
                  $sampled(bit_idx), $sampled(o_csr_pc), $sampled(exp_csr_pc[bit_idx]));
      end

   task automatic clear_req();
      q_rs1     = '0;
      q_rs2     = '0;
      q_rd      = '0;
      q_rd_wen  = 1'b0;
      q_src     = 0;
      q_src_en  = 1'b1;
      q_rd_val  = '0;
      q_csr_en  = 1'b0;
      q_slot    = '0;
      q_csr_val = '0;
      q_trap    = 1'b0;
      q_mret    = 1'b0;
      q_mem_op  = 1'b0;
      q_mepc    = '0;
      q_bufreg  = '0;
      q_bad_pc  = '0;
   endtask

   task automatic run_txn();
      logic [XLEN-1:0] rd_bits;
      int              rport;
      int              n;
      int              waited;
      // Read port 1 priority: mtvec, mepc, CSR, rs2
      rport   = q_trap ? 33 : (q_mret ? 34 : (q_csr_en ? 32 + q_slot : q_rs2));
      // alu and csr sources count only with their enable
      rd_bits = ((q_src == 1 || q_src == 2) && !q_src_en) ? '0 : q_rd_val;
      exp_rs1    <= model[q_rs1];
      exp_rs2    <= model[rport];
      exp_csr    <= q_csr_en ? model[rport] : '0;
      exp_csr_pc <= model[rport];
      @(posedge i_clk);
      i_rreq      <= 1'b1;
      i_rs1_raddr <= q_rs1;
      i_rs2_raddr <= q_rs2;
      i_rd_waddr  <= q_rd;
      i_rd_wen    <= q_rd_wen;
      i_rd_alu_en <= (q_src == 1) & q_src_en;
      i_rd_csr_en <= (q_src == 2) & q_src_en;
      i_csr_en    <= q_csr_en;
      i_csr_addr  <= csr_slot_e'(q_slot);
      i_trap      <= q_trap;
      i_mret      <= q_mret;
      i_mem_op    <= q_mem_op;
      @(posedge i_clk);
      i_rreq <= 1'b0;
      waited = 0;
      while (!o_ready && waited < 6) begin
         @(posedge i_clk);
         waited++;
      end
      if (!o_ready) begin
         err_cnt++;
         $display("%0t: no ready pulse within 6 cycles of the request", $time);
      end else begin
         for (n = 0; n < XLEN; n++) begin
            in_data    <= 1'b1;
            bit_idx    <= 5'(n);
            i_ctrl_rd  <= (q_src == 0) & q_rd_val[n];
            i_alu_rd   <= (q_src == 1) & q_rd_val[n];
            i_csr_rd   <= (q_src == 2) & q_rd_val[n];
            i_mem_rd   <= (q_src == 3) & q_rd_val[n];
            i_csr      <= q_csr_val[n];
            i_mepc     <= q_mepc[n];
            i_bufreg_q <= q_bufreg[n];
            i_bad_pc   <= q_bad_pc[n];
            @(posedge i_clk);
         end
         in_data <= 1'b0;
      end
      // A trap takes both write ports
      if (q_trap) begin
         model[35] = q_mem_op ? q_bufreg : q_bad_pc;
         model[34] = q_mepc;
      end else begin
         if (q_rd_wen && q_rd != 0) begin
            model[q_rd] = rd_bits;
         end
         if (q_csr_en) begin
            model[32 + q_slot] = q_csr_val;
         end
      end
      // Room for the final word commits
      repeat (2) @(posedge i_clk);
      txn_cnt++;
   endtask

   task automatic begin_test(input string name);
      cur_name       = name;
      test_err_start = err_cnt;
      test_cnt++;
   endtask

   task automatic end_test();
      $display("%0t: %s: %0d errors", $time, cur_name, err_cnt - test_err_start);
   endtask

   initial begin
      #(WATCHDOG_CYCLES * CLK_PERIOD);
      $display("watchdog expired after %0d cycles, the run did not complete", WATCHDOG_CYCLES);
      $display("test failed");
      $finish;
   end

   initial begin
      int k;
      i_clk       = 1'b0;
      i_reset     = 1'b1;
      i_rreq      = 1'b0;
      i_trap      = 1'b0;
      i_mret      = 1'b0;
      i_mepc      = 1'b0;
      i_mem_op    = 1'b0;
      i_bufreg_q  = 1'b0;
      i_bad_pc    = 1'b0;
      i_csr_en    = 1'b0;
      i_csr_addr  = CSR_MSCRATCH;
      i_csr       = 1'b0;
      i_rd_wen    = 1'b0;
      i_rd_waddr  = '0;
      i_ctrl_rd   = 1'b0;
      i_alu_rd    = 1'b0;
      i_rd_alu_en = 1'b0;
      i_csr_rd    = 1'b0;
      i_rd_csr_en = 1'b0;
      i_mem_rd    = 1'b0;
      i_rs1_raddr = '0;
      i_rs2_raddr = '0;
      in_data     = 1'b0;
      bit_idx     = '0;
      exp_rs1     = '0;
      exp_rs2     = '0;
      exp_csr     = '0;
      exp_csr_pc  = '0;
      lfsr        = 32'h07768e4c;
      err_cnt     = 0;
      txn_cnt     = 0;
      test_cnt    = 0;
      for (k = 0; k < RF_REGS; k++) begin
         model[k] = '0;
      end
      repeat (3) @(posedge i_clk);
      i_reset <= 1'b0;
      // Idle cycles where o_ready must stay low
      repeat (4) @(posedge i_clk);

      begin_test("reset and timing");
      clear_req();
      run_txn();
      end_test();

      begin_test("general register writes");
      // ctrl, alu, csr and mem sources in turn
      for (k = 0; k < 4; k++) begin
         clear_req();
         q_rd     = 5'(5 + 7 * k);
         q_rd_wen = 1'b1;
         q_src    = k;
         q_rd_val = rand_bits(32);
         run_txn();
      end
      clear_req();
      q_rd_wen = 1'b1;
      q_rd_val = rand_bits(32);
      run_txn();
      clear_req();
      q_rs1 = 5'd5;
      q_rs2 = 5'd12;
      run_txn();
      // alu source with its enable low clears x5
      clear_req();
      q_rs1    = 5'd19;
      q_rs2    = 5'd26;
      q_rd     = 5'd5;
      q_rd_wen = 1'b1;
      q_src    = 1;
      q_src_en = 1'b0;
      q_rd_val = rand_bits(32);
      run_txn();
      clear_req();
      q_rs2 = 5'd5;
      run_txn();
      end_test();

      begin_test("read before write");
      clear_req();
      q_rs1    = 5'd12;
      q_rs2    = 5'd12;
      q_rd     = 5'd12;
      q_rd_wen = 1'b1;
      q_rd_val = rand_bits(32);
      run_txn();
      clear_req();
      q_rs1 = 5'd12;
      run_txn();
      end_test();

      begin_test("csr access");
      for (k = 0; k < 8; k++) begin
         clear_req();
         q_csr_en  = 1'b1;
         q_slot    = 2'(k);
         q_csr_val = rand_bits(32);
         q_rs1     = 5'(rand_bits(5));
         run_txn();
         if (k == 3) begin
            // CSR data without the enable must not land anywhere
            clear_req();
            q_csr_val = rand_bits(32);
            q_rs2     = 5'd19;
            run_txn();
         end
      end
      end_test();

      begin_test("trap");
      for (k = 0; k < 2; k++) begin
         clear_req();
         q_trap   = 1'b1;
         q_mem_op = (k == 0);
         q_mepc   = rand_bits(32);
         q_bufreg = rand_bits(32);
         q_bad_pc = rand_bits(32);
         q_rs2    = 5'(rand_bits(5));
         run_txn();
         clear_req();
         q_csr_en  = 1'b1;
         q_slot    = 2'd3;
         q_csr_val = rand_bits(32);
         run_txn();
         if (k == 0) begin
            clear_req();
            q_csr_en  = 1'b1;
            q_slot    = 2'd2;
            q_csr_val = rand_bits(32);
            run_txn();
         end
      end
      end_test();

      begin_test("mret");
      clear_req();
      q_mret = 1'b1;
      run_txn();
      end_test();

      $display("summary: %0d tests, %0d transactions, %0d errors", test_cnt, txn_cnt, err_cnt);
      if (err_cnt == 0) begin
         $display("test passed");
      end else begin
         $display("test failed");
      end
      $finish;
   end

endmodule

//--- vlog.f
src/srf_pkg.sv
src/srf_rf_if.sv
src/srf_ram_if.sv
src/srf_ram.sv
src/srf_top.sv
testbench/srf_tb.sv
